// File: Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing -Wall
TOP       = tb_rv_core
FILELIST  = src.f

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard *.svh)
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf obj_dir

// File: rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// datapath widths
`define RV_XLEN      32
`define RV_REG_BITS  5
`define RV_NUM_REGS  32

// major opcodes
`define RV_OPC_OP      7'b0110011
`define RV_OPC_OP_IMM  7'b0010011
`define RV_OPC_LUI     7'b0110111

// funct3, shared by OP and OP-IMM
`define RV_F3_ADD   3'b000
`define RV_F3_SLL   3'b001
`define RV_F3_SLT   3'b010
`define RV_F3_SLTU  3'b011
`define RV_F3_XOR   3'b100
`define RV_F3_SR    3'b101
`define RV_F3_OR    3'b110
`define RV_F3_AND   3'b111

// funct7 bit picking SUB over ADD and SRA over SRL
`define RV_F7_ALT_BIT  30

`endif

// File: rv_core.sv
module rv_core (
  input  logic            clk_i,
  input  logic            reset_i,
  input  logic            instr_valid_i,
  input  rv_pkg::instr_t  instr_i,
  output rv_pkg::result_t retire_o
);

  rv_pkg::decoded_t dec;
  rv_pkg::result_t  exe;
  rv_pkg::word_t    rs1_data;
  rv_pkg::word_t    rs2_data;

  // stage 1, decode
  rv_decode rv_decode_i (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .dec_o         (dec)
  );

  // stage 2, operand fetch and alu
  rv_execute rv_execute_i (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .dec_i      (dec),
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data),
    .exe_o      (exe)
  );

  // stage 3, register file and retire
  rv_writeback rv_writeback_i (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .exe_i      (exe),
    .rs1_addr_i (dec.rs1),
    .rs2_addr_i (dec.rs2),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .retire_o   (retire_o)
  );

endmodule

// File: rv_decode.sv
`include "rv_consts.svh"

module rv_decode (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             instr_valid_i,
  input  rv_pkg::instr_t   instr_i,
  output rv_pkg::decoded_t dec_o
);

  logic [6:0]       opcode;
  logic [2:0]       funct3;
  logic             alt;
  rv_pkg::alu_op_e  f3_op;
  rv_pkg::decoded_t dec_next;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign alt    = instr_i[`RV_F7_ALT_BIT];

  //////////////////////////////
  // funct3 to alu op
  //////////////////////////////

  // common to OP and OP-IMM, SUB is handled below
  always_comb begin
    case (funct3)
      `RV_F3_ADD:  f3_op = rv_pkg::ALU_ADD;
      `RV_F3_SLL:  f3_op = rv_pkg::ALU_SLL;
      `RV_F3_SLT:  f3_op = rv_pkg::ALU_SLT;
      `RV_F3_SLTU: f3_op = rv_pkg::ALU_SLTU;
      `RV_F3_XOR:  f3_op = rv_pkg::ALU_XOR;
      `RV_F3_SR:   f3_op = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
      `RV_F3_OR:   f3_op = rv_pkg::ALU_OR;
      `RV_F3_AND:  f3_op = rv_pkg::ALU_AND;
    endcase
  end

  //////////////////////////////
  // field extraction
  //////////////////////////////

  always_comb begin
    // unsupported words fall through as rd 0, imm 0, pass_b
    dec_next         = '0;
    dec_next.valid   = instr_valid_i;
    dec_next.op      = rv_pkg::ALU_PASS_B;
    dec_next.use_imm = 1'b1;

    case (opcode)
      `RV_OPC_OP: begin
        if (funct3 == `RV_F3_ADD && alt) begin
          dec_next.op = rv_pkg::ALU_SUB;
        end else begin
          dec_next.op = f3_op;
        end
        dec_next.rd      = instr_i[11:7];
        dec_next.rs1     = instr_i[19:15];
        dec_next.rs2     = instr_i[24:20];
        dec_next.use_imm = 1'b0;
      end
      `RV_OPC_OP_IMM: begin
        dec_next.op  = f3_op;
        dec_next.rd  = instr_i[11:7];
        dec_next.rs1 = instr_i[19:15];
        // shifts take only the shamt field
        if (funct3 == `RV_F3_SLL || funct3 == `RV_F3_SR) begin
          dec_next.imm = rv_pkg::word_t'(instr_i[24:20]);
        end else begin
          dec_next.imm = {{(`RV_XLEN-12){instr_i[31]}}, instr_i[31:20]};
        end
      end
      `RV_OPC_LUI: begin
        dec_next.rd  = instr_i[11:7];
        dec_next.imm = {instr_i[31:12], 12'b0};
      end
      default: begin
      end
    endcase
  end

  // payload follows every cycle, only valid needs clearing
  always_ff @(posedge clk_i) begin
    dec_o <= dec_next;
    if (reset_i) begin
      dec_o.valid <= 1'b0;
    end
  end

endmodule

// File: rv_execute.sv
module rv_execute (
  input  logic             clk_i,
  input  logic             reset_i,
  input  rv_pkg::decoded_t dec_i,
  input  rv_pkg::word_t    rs1_data_i,
  input  rv_pkg::word_t    rs2_data_i,
  output rv_pkg::result_t  exe_o
);

  logic            fwd_rs1;
  logic            fwd_rs2;
  rv_pkg::word_t   rs1_val;
  rv_pkg::word_t   rs2_val;
  rv_pkg::word_t   op_a;
  rv_pkg::word_t   op_b;
  logic [4:0]      shamt;
  rv_pkg::word_t   alu_result;
  rv_pkg::result_t exe_next;

  //////////////////////////////
  // operand forwarding
  //////////////////////////////

  // older results are already in the register file,
  // so only the instruction sitting in exe_o can be newer
  assign fwd_rs1 = exe_o.valid && (exe_o.rd == dec_i.rs1) && (exe_o.rd != '0);
  assign fwd_rs2 = exe_o.valid && (exe_o.rd == dec_i.rs2) && (exe_o.rd != '0);

  assign rs1_val = fwd_rs1 ? exe_o.data : rs1_data_i;
  assign rs2_val = fwd_rs2 ? exe_o.data : rs2_data_i;

  assign op_a  = rs1_val;
  assign op_b  = dec_i.use_imm ? dec_i.imm : rs2_val;
  assign shamt = op_b[4:0];

  //////////////////////////////
  // alu
  //////////////////////////////

  always_comb begin
    case (dec_i.op)
      rv_pkg::ALU_ADD:    alu_result = op_a + op_b;
      rv_pkg::ALU_SUB:    alu_result = op_a - op_b;
      rv_pkg::ALU_SLL:    alu_result = op_a << shamt;
      rv_pkg::ALU_SLT:    alu_result = rv_pkg::word_t'($signed(op_a) < $signed(op_b));
      rv_pkg::ALU_SLTU:   alu_result = rv_pkg::word_t'(op_a < op_b);
      rv_pkg::ALU_XOR:    alu_result = op_a ^ op_b;
      rv_pkg::ALU_SRL:    alu_result = op_a >> shamt;
      rv_pkg::ALU_SRA:    alu_result = rv_pkg::word_t'($signed(op_a) >>> shamt);
      rv_pkg::ALU_OR:     alu_result = op_a | op_b;
      rv_pkg::ALU_AND:    alu_result = op_a & op_b;
      rv_pkg::ALU_PASS_B: alu_result = op_b;
      default:            alu_result = '0;
    endcase
  end

  always_comb begin
    exe_next.valid = dec_i.valid;
    exe_next.rd    = dec_i.rd;
    exe_next.data  = alu_result;
  end

  // result register, valid cleared on reset
  always_ff @(posedge clk_i) begin
    exe_o <= exe_next;
    if (reset_i) begin
      exe_o.valid <= 1'b0;
    end
  end

endmodule

// File: rv_pkg.sv
`include "rv_consts.svh"

package rv_pkg;

  //////////////////////////////
  // basic widths
  //////////////////////////////

  typedef logic [`RV_XLEN-1:0]     word_t;
  typedef logic [`RV_XLEN-1:0]     instr_t;
  typedef logic [`RV_REG_BITS-1:0] reg_addr_t;

  // alu operations, pass_b carries the LUI immediate through
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_e;

  //////////////////////////////
  // stage payloads
  //////////////////////////////

  // decode to execute
  typedef struct packed {
    logic      valid;
    alu_op_e   op;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    logic      use_imm;
    word_t     imm;
  } decoded_t;

  // execute to writeback, also the retire output
  typedef struct packed {
    logic      valid;
    reg_addr_t rd;
    word_t     data;
  } result_t;

endpackage

// File: rv_writeback.sv
`include "rv_consts.svh"

module rv_writeback (
  input  logic               clk_i,
  input  logic               reset_i,
  input  rv_pkg::result_t    exe_i,
  input  rv_pkg::reg_addr_t  rs1_addr_i,
  input  rv_pkg::reg_addr_t  rs2_addr_i,
  output rv_pkg::word_t      rs1_data_o,
  output rv_pkg::word_t      rs2_data_o,
  output rv_pkg::result_t    retire_o
);

  rv_pkg::word_t regs [`RV_NUM_REGS];
  logic          reg_write;

  // x0 is never written
  assign reg_write = exe_i.valid && (exe_i.rd != '0);

  //////////////////////////////
  // register file
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (reg_write) begin
      regs[exe_i.rd] <= exe_i.data;
    end
  end

  // async read, x0 forced to zero
  assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

  //////////////////////////////
  // retire
  //////////////////////////////

  // same edge as the register file write
  always_ff @(posedge clk_i) begin
    retire_o <= exe_i;
    if (reset_i) begin
      retire_o.valid <= 1'b0;
    end
  end

endmodule

// File: src.f
+incdir+.
rv_pkg.sv
rv_decode.sv
rv_execute.sv
rv_writeback.sv
rv_core.sv
tb_rv_core.sv

// File: tb_rv_core.sv
`include "rv_consts.svh"

module tb_rv_core;

  localparam int RESET_CYCLES = 8;
  localparam int ISSUE_CYCLES = 400;
  localparam int CYCLE_LIMIT  = RESET_CYCLES + ISSUE_CYCLES + 20;

  logic            clk_i;
  logic            reset_i;
  logic            instr_valid_i;
  rv_pkg::instr_t  instr_i;
  rv_pkg::result_t retire_o;

  int                cycle;
  int                value_errors;
  int                protocol_errors;
  int                leftover;
  rv_pkg::word_t     ref_regs [`RV_NUM_REGS];
  rv_pkg::instr_t    directed_q [$];
  rv_pkg::reg_addr_t exp_rd_q [$];
  rv_pkg::word_t     exp_data_q [$];
  int                exp_cycle_q [$];
  rv_pkg::reg_addr_t exp_rd;
  rv_pkg::word_t     exp_data;
  int                exp_cycle;

  rv_core rv_core_i (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .retire_o      (retire_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // rising edges seen so far
  initial begin
    forever begin
      @(posedge clk_i);
      cycle <= cycle + 1;
    end
  end

  //////////////////////////////
  // instruction encoders
  //////////////////////////////

  function automatic rv_pkg::instr_t reg_reg_word(input logic [6:0] f7,
      input rv_pkg::reg_addr_t rs2, input rv_pkg::reg_addr_t rs1,
      input logic [2:0] f3, input rv_pkg::reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, `RV_OPC_OP};
  endfunction

  function automatic rv_pkg::instr_t imm_word(input logic [11:0] imm12,
      input rv_pkg::reg_addr_t rs1, input logic [2:0] f3, input rv_pkg::reg_addr_t rd);
    return {imm12, rs1, f3, rd, `RV_OPC_OP_IMM};
  endfunction

  function automatic rv_pkg::instr_t upper_word(input logic [19:0] imm20,
      input rv_pkg::reg_addr_t rd);
    return {imm20, rd, `RV_OPC_LUI};
  endfunction

  // legal OP, OP-IMM or LUI word on registers x0 to x7
  function automatic rv_pkg::instr_t random_instr();
    int                kind;
    logic [2:0]        f3;
    logic              alt;
    logic [4:0]        shamt;
    logic [11:0]       imm12;
    rv_pkg::reg_addr_t rd;
    rv_pkg::reg_addr_t rs1;
    rv_pkg::reg_addr_t rs2;
    kind  = $urandom_range(0, 8);
    f3    = 3'($urandom_range(0, 7));
    alt   = 1'($urandom_range(0, 1));
    shamt = 5'($urandom);
    rd    = rv_pkg::reg_addr_t'($urandom_range(0, 7));
    rs1   = rv_pkg::reg_addr_t'($urandom_range(0, 7));
    rs2   = rv_pkg::reg_addr_t'($urandom_range(0, 7));
    if (kind < 4) begin
      if (f3 != `RV_F3_ADD && f3 != `RV_F3_SR) begin
        alt = 1'b0;
      end
      return reg_reg_word({1'b0, alt, 5'b0}, rs2, rs1, f3, rd);
    end else if (kind < 8) begin
      if (f3 == `RV_F3_SLL) begin
        imm12 = {7'b0, shamt};
      end else if (f3 == `RV_F3_SR) begin
        imm12 = {1'b0, alt, 5'b0, shamt};
      end else begin
        imm12 = 12'($urandom);
      end
      return imm_word(imm12, rs1, f3, rd);
    end
    return upper_word(20'($urandom), rd);
  endfunction

  //////////////////////////////
  // reference model
  //////////////////////////////

  // result of one instruction against the model register array
  function automatic rv_pkg::result_t expected_result(input rv_pkg::instr_t w);
    rv_pkg::result_t r;
    rv_pkg::word_t   a;
    rv_pkg::word_t   b;
    logic            is_op;
    logic            alt;
    r       = '0;
    r.valid = 1'b1;
    is_op   = (w[6:0] == `RV_OPC_OP);
    alt     = w[`RV_F7_ALT_BIT];
    a       = ref_regs[w[19:15]];
    // low five bits of the I immediate are the shamt field
    b       = is_op ? ref_regs[w[24:20]] : {{20{w[31]}}, w[31:20]};
    if (is_op || w[6:0] == `RV_OPC_OP_IMM) begin
      r.rd = w[11:7];
      case (w[14:12])
        `RV_F3_ADD:  r.data = (is_op && alt) ? a - b : a + b;
        `RV_F3_SLL:  r.data = a << b[4:0];
        `RV_F3_SLT:  r.data = {31'b0, $signed(a) < $signed(b)};
        `RV_F3_SLTU: r.data = {31'b0, a < b};
        `RV_F3_XOR:  r.data = a ^ b;
        `RV_F3_SR: begin
          // arithmetic shift fills with the sign bit
          if (alt) begin
            r.data = $signed(a) >>> b[4:0];
          end else begin
            r.data = a >> b[4:0];
          end
        end
        `RV_F3_OR:   r.data = a | b;
        `RV_F3_AND:  r.data = a & b;
      endcase
    end else if (w[6:0] == `RV_OPC_LUI) begin
      r.rd   = w[11:7];
      r.data = {w[31:12], 12'b0};
    end
    // anything else stays rd 0, data 0
    return r;
  endfunction

  task automatic issue(input rv_pkg::instr_t w);
    rv_pkg::result_t r;
    instr_valid_i <= 1'b1;
    instr_i       <= w;
    r = expected_result(w);
    if (r.rd != '0) begin
      ref_regs[r.rd] = r.data;
    end
    exp_rd_q.push_back(r.rd);
    exp_data_q.push_back(r.data);
    // strobe is high in the cycle after this edge
    exp_cycle_q.push_back(cycle + 1);
  endtask

  // junk word on the bus with the strobe low
  task automatic idle(input rv_pkg::instr_t w);
    instr_valid_i <= 1'b0;
    instr_i       <= w;
  endtask

  //////////////////////////////
  // stimulus
  //////////////////////////////

  initial begin
    void'($urandom(32'h42933af4));
    reset_i       = 1'b1;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    for (int i = 0; i < `RV_NUM_REGS; i++) begin
      ref_regs[i] = '0;
    end
    directed_q.push_back(imm_word(12'hffb, 5'd0, `RV_F3_ADD, 5'd1));        // addi x1,-5
    directed_q.push_back(imm_word(12'd100, 5'd0, `RV_F3_ADD, 5'd2));        // addi x2,100
    directed_q.push_back(reg_reg_word(7'h00, 5'd2, 5'd1, `RV_F3_ADD, 5'd3));
    directed_q.push_back(reg_reg_word(7'h20, 5'd1, 5'd3, `RV_F3_ADD, 5'd4)); // sub
    directed_q.push_back(reg_reg_word(7'h00, 5'd2, 5'd1, `RV_F3_SLT, 5'd5));
    directed_q.push_back(reg_reg_word(7'h00, 5'd2, 5'd1, `RV_F3_SLTU, 5'd5));
    directed_q.push_back(imm_word(12'hfff, 5'd1, `RV_F3_SLT, 5'd6));
    directed_q.push_back(imm_word(12'hfff, 5'd1, `RV_F3_SLTU, 5'd6));
    directed_q.push_back(imm_word({7'h20, 5'd1}, 5'd1, `RV_F3_SR, 5'd7));   // srai
    directed_q.push_back(imm_word({7'h00, 5'd4}, 5'd1, `RV_F3_SR, 5'd7));   // srli
    directed_q.push_back(reg_reg_word(7'h20, 5'd2, 5'd1, `RV_F3_SR, 5'd7)); // sra
    directed_q.push_back(upper_word(20'habcde, 5'd3));
    directed_q.push_back(imm_word(12'h800, 5'd3, `RV_F3_XOR, 5'd3));
    directed_q.push_back(imm_word(12'd7, 5'd1, `RV_F3_ADD, 5'd0));          // to x0
    directed_q.push_back(reg_reg_word(7'h00, 5'd0, 5'd0, `RV_F3_ADD, 5'd4));
    directed_q.push_back(32'hffff_ffff);
    directed_q.push_back(32'h0020_8063);                                    // beq
    directed_q.push_back(reg_reg_word(7'h00, 5'd4, 5'd3, `RV_F3_ADD, 5'd5));
    directed_q.push_back(imm_word(12'h7ff, 5'd0, `RV_F3_OR, 5'd6));
    directed_q.push_back(imm_word(12'h0f0, 5'd6, `RV_F3_AND, 5'd6));

    repeat (RESET_CYCLES) @(posedge clk_i);
    reset_i <= 1'b0;
    for (int i = 0; i < ISSUE_CYCLES; i++) begin
      @(posedge clk_i);
      if (directed_q.size() != 0) begin
        issue(directed_q.pop_front());
      end else if ($urandom_range(0, 3) != 0) begin
        issue(random_instr());
      end else begin
        idle(random_instr());
      end
    end
    @(posedge clk_i);
    instr_valid_i <= 1'b0;

    // drain, then a little longer for stray pulses
    while (exp_rd_q.size() != 0) @(negedge clk_i);
    repeat (2) @(negedge clk_i);
    leftover = exp_rd_q.size();
    if (leftover != 0) begin
      $display("%0d instructions never retired", leftover);
    end
    $display("checks done: %0d value errors, %0d protocol errors, %0d never retired",
      value_errors, protocol_errors, leftover);
    if (value_errors == 0 && protocol_errors == 0 && leftover == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  //////////////////////////////
  // retire checker
  //////////////////////////////

  // outputs sampled on the falling edge
  initial begin
    forever begin
      @(negedge clk_i);
      if (!reset_i && $isunknown(retire_o.valid)) begin
        $display("retire valid is unknown at time %0t", $time);
        protocol_errors++;
      end else if (retire_o.valid === 1'b1) begin
        if (exp_rd_q.size() == 0) begin
          $display("retire pulse at time %0t with no instruction in flight", $time);
          protocol_errors++;
        end else begin
          exp_rd    = exp_rd_q.pop_front();
          exp_data  = exp_data_q.pop_front();
          exp_cycle = exp_cycle_q.pop_front();
          if (retire_o.rd !== exp_rd) begin
            $display("error at %0t: retire_o.rd expected %0d, got %0d",
              $time, exp_rd, retire_o.rd);
            value_errors++;
          end
          if (retire_o.data !== exp_data) begin
            $display("error at %0t: retire_o.data expected %h, got %h",
              $time, exp_data, retire_o.data);
            value_errors++;
          end
          if (cycle != exp_cycle + 3) begin
            $display("error at %0t: retire_o.valid cycle expected %0d, got %0d",
              $time, exp_cycle + 3, cycle);
            value_errors++;
          end
        end
      end
    end
  end

  initial begin
    while (cycle < CYCLE_LIMIT) @(posedge clk_i);
    $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("Simulation failed");
    $finish;
  end

endmodule
